// File: rtl/image_stream_pkg.sv
package image_stream_pkg;

   // Sample and side-band widths of the tagged stream
   localparam int PIXEL_WIDTH = 8;
   localparam int META_WIDTH  = 16;

   // Longest supported line, in pixels
   localparam int MAX_COLS  = 1288;
   // Column counters also hold a line length and one idle slot past it
   localparam int COL_WIDTH = $clog2(MAX_COLS + 2);

   // Sample tags carried with every strobe
   typedef enum logic [2:0] {
      DT_FRAME_START = 3'd0,
      DT_FRAME_END   = 3'd1,
      DT_LINE_START  = 3'd2,
      DT_PIXEL       = 3'd3,
      DT_LINE_END    = 3'd4
   } dtype_t;

   // Pixel tags carry image data, the frame markers carry meta data
   function automatic logic is_pixel(input dtype_t dtype);
      return dtype inside {DT_LINE_START, DT_PIXEL, DT_LINE_END};
   endfunction

endpackage

// File: rtl/unsharp_filter_pkg.sv
package unsharp_filter_pkg;

   // Fixed 3x3 window, one-pixel replicated border
   localparam int KERNEL_SIZE = 3;

   // Signed Q1.7 coefficients
   localparam int COEFF_WIDTH      = 8;
   localparam int COEFF_FRAC_WIDTH = 7;

   // 9-bit signed pixel times Q1.7, three terms
   localparam int ROW_SUM_WIDTH = 18;
   // Row sum times Q1.7, three terms
   localparam int ACC_WIDTH     = 28;

   // Two coefficient stages stack their fraction bits
   localparam int ACC_FRAC_WIDTH = 2 * COEFF_FRAC_WIDTH;
   // Half an output LSB, for round-half-up
   localparam logic signed [ACC_WIDTH-1:0] ACC_ROUND = 1 << (ACC_FRAC_WIDTH - 1);

   // Line buffer sequencing
   typedef enum logic [1:0] {
      LB_IDLE,
      LB_FIRST_LINE,
      LB_STREAM,
      LB_FLUSH
   } lb_state_t;

endpackage

// File: rtl/window_row_if.sv
interface window_row_if
   import image_stream_pkg::*;
();

   logic                   valid;
   dtype_t                 dtype;
   logic [PIXEL_WIDTH-1:0] pixel;
   logic [META_WIDTH-1:0]  meta;

   // Line buffer side
   modport source (output valid, output dtype, output pixel, output meta);

   // Row filter side
   modport sink (input valid, input dtype, input pixel, input meta);

endinterface

// File: rtl/row_sum_if.sv
interface row_sum_if
   import image_stream_pkg::*, unsharp_filter_pkg::*;
();

   logic                            valid;
   dtype_t                          dtype;
   logic signed [ROW_SUM_WIDTH-1:0] sum;
   logic [PIXEL_WIDTH-1:0]          center;
   logic [META_WIDTH-1:0]           meta;

   modport source (output valid, output dtype, output sum, output center, output meta);

   // Blend stage side
   modport sink (input valid, input dtype, input sum, input center, input meta);

endinterface

// File: rtl/window_line_buffer.sv
module window_line_buffer
   import image_stream_pkg::*, unsharp_filter_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   in_dv,
   input  dtype_t                 in_dtype,
   input  logic [PIXEL_WIDTH-1:0] in_pixel,
   input  logic [META_WIDTH-1:0]  in_meta,
   window_row_if.source           taps [KERNEL_SIZE]
);

   // last_line holds the newest complete line, prev_line the one above it
   logic [PIXEL_WIDTH-1:0] prev_line [MAX_COLS];
   logic [PIXEL_WIDTH-1:0] last_line [MAX_COLS];

   lb_state_t              state;
   logic [COL_WIDTH-1:0]   col;
   logic [COL_WIDTH-1:0]   line_len;
   logic                   top_valid;
   logic [META_WIDTH-1:0]  end_meta;

   logic [PIXEL_WIDTH-1:0] rd_prev;
   logic [PIXEL_WIDTH-1:0] rd_last;
   logic                   pixel_in;
   logic                   flush_done;

   logic                   emit;
   dtype_t                 emit_dtype;
   logic [META_WIDTH-1:0]  emit_meta;
   logic [PIXEL_WIDTH-1:0] emit_top;
   logic [PIXEL_WIDTH-1:0] emit_bottom;

   logic                   tap_valid;
   dtype_t                 tap_dtype;
   logic [META_WIDTH-1:0]  tap_meta;
   logic [PIXEL_WIDTH-1:0] tap_pixel [KERNEL_SIZE];

   assign rd_prev    = prev_line[col];
   assign rd_last    = last_line[col];
   assign pixel_in   = in_dv && is_pixel(in_dtype) && state inside {LB_FIRST_LINE, LB_STREAM};
   // One idle slot after the replayed line end, then the frame-end marker
   assign flush_done = (col == line_len + 1'b1);

   // Shift the column down one line as the new pixel arrives
   always_ff @(posedge clk) begin
      if (pixel_in) begin
         last_line[col] <= in_pixel;
         prev_line[col] <= rd_last;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= LB_IDLE;
         col       <= '0;
         line_len  <= '0;
         top_valid <= 1'b0;
      end else begin
         case (state)
            LB_IDLE: begin
               if (in_dv && in_dtype == DT_FRAME_START) begin
                  state     <= LB_FIRST_LINE;
                  col       <= '0;
                  top_valid <= 1'b0;
               end
            end
            LB_FIRST_LINE, LB_STREAM: begin
               if (pixel_in) begin
                  if (in_dtype == DT_LINE_END) begin
                     col       <= '0;
                     line_len  <= col + 1'b1;
                     state     <= LB_STREAM;
                     top_valid <= (state == LB_STREAM);
                  end else begin
                     col <= col + 1'b1;
                  end
               end else if (in_dv && in_dtype == DT_FRAME_END) begin
                  // A frame without a complete line has nothing to replay
                  state <= (state == LB_STREAM) ? LB_FLUSH : LB_IDLE;
               end else if (in_dv && in_dtype == DT_FRAME_START) begin
                  state     <= LB_FIRST_LINE;
                  col       <= '0;
                  top_valid <= 1'b0;
               end
            end
            LB_FLUSH: begin
               if (flush_done) begin
                  state <= LB_IDLE;
                  col   <= '0;
               end else begin
                  col <= col + 1'b1;
               end
            end
            default: state <= LB_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == LB_STREAM && in_dv && in_dtype == DT_FRAME_END) begin
         end_meta <= in_meta;
      end
   end

   always_comb begin
      emit        = 1'b0;
      emit_dtype  = in_dtype;
      emit_meta   = in_meta;
      // Top row replicates the center until a line above it exists
      emit_top    = top_valid ? rd_prev : rd_last;
      emit_bottom = in_pixel;
      case (state)
         LB_IDLE:       emit = in_dv && in_dtype == DT_FRAME_START;
         LB_FIRST_LINE: emit = in_dv && !is_pixel(in_dtype);
         LB_STREAM:     emit = in_dv && in_dtype != DT_FRAME_END;
         LB_FLUSH: begin
            emit        = (col != line_len);
            emit_meta   = end_meta;
            emit_bottom = rd_last;
            if (flush_done) begin
               emit_dtype = DT_FRAME_END;
            end else if (col == line_len - 1'b1) begin
               emit_dtype = DT_LINE_END;
            end else if (col == '0) begin
               emit_dtype = DT_LINE_START;
            end else begin
               emit_dtype = DT_PIXEL;
            end
         end
         default: emit = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         tap_valid <= 1'b0;
      end else begin
         tap_valid <= emit;
      end
   end

   always_ff @(posedge clk) begin
      tap_dtype    <= emit_dtype;
      tap_meta     <= emit_meta;
      tap_pixel[0] <= emit_top;
      tap_pixel[1] <= rd_last;
      tap_pixel[2] <= emit_bottom;
   end

   for (genvar r = 0; r < KERNEL_SIZE; r++) begin : g_taps
      assign taps[r].valid = tap_valid;
      assign taps[r].dtype = tap_dtype;
      assign taps[r].pixel = tap_pixel[r];
      assign taps[r].meta  = tap_meta;
   end

endmodule

// File: rtl/row_filter.sv
module row_filter
   import image_stream_pkg::*, unsharp_filter_pkg::*;
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic signed [KERNEL_SIZE*COEFF_WIDTH-1:0] coeffs,
   window_row_if.sink                              tap,
   row_sum_if.source                               sum_out
);

   logic [PIXEL_WIDTH-1:0]          left_q;
   logic [PIXEL_WIDTH-1:0]          center_q;
   dtype_t                          center_dtype;
   logic                            pending;

   logic                            tap_pixel;
   logic                            tap_marker;
   logic [PIXEL_WIDTH-1:0]          right_pixel;

   logic                            out_valid;
   dtype_t                          out_dtype;
   logic signed [ROW_SUM_WIDTH-1:0] out_sum;
   logic [PIXEL_WIDTH-1:0]          out_center;
   logic [META_WIDTH-1:0]           out_meta;

   // Pixels are unsigned, so widen with a zero sign bit before weighting
   function automatic logic signed [ROW_SUM_WIDTH-1:0] weigh(
      input logic [PIXEL_WIDTH-1:0] left,
      input logic [PIXEL_WIDTH-1:0] center,
      input logic [PIXEL_WIDTH-1:0] right
   );
      return $signed(coeffs[0 +: COEFF_WIDTH]) * $signed({1'b0, left})
           + $signed(coeffs[COEFF_WIDTH +: COEFF_WIDTH]) * $signed({1'b0, center})
           + $signed(coeffs[2*COEFF_WIDTH +: COEFF_WIDTH]) * $signed({1'b0, right});
   endfunction

   assign tap_pixel   = tap.valid && is_pixel(tap.dtype);
   assign tap_marker  = tap.valid && !is_pixel(tap.dtype);
   // Last column of a line repeats itself as the right neighbor
   assign right_pixel = pending ? center_q : tap.pixel;

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         pending   <= 1'b0;
      end else begin
         out_valid <= pending || tap_marker || (tap_pixel && tap.dtype != DT_LINE_START);
         pending   <= tap_pixel && tap.dtype == DT_LINE_END;
      end
   end

   always_ff @(posedge clk) begin
      out_sum    <= weigh(left_q, center_q, right_pixel);
      out_center <= center_q;
      out_dtype  <= tap_marker ? tap.dtype : center_dtype;
      if (tap_marker) begin
         out_meta <= tap.meta;
      end
      if (tap_pixel) begin
         // Left neighbor of column 0 is column 0 itself
         left_q       <= (tap.dtype == DT_LINE_START) ? tap.pixel : center_q;
         center_q     <= tap.pixel;
         center_dtype <= tap.dtype;
      end
   end

   assign sum_out.valid  = out_valid;
   assign sum_out.dtype  = out_dtype;
   assign sum_out.sum    = out_sum;
   assign sum_out.center = out_center;
   assign sum_out.meta   = out_meta;

endmodule

// File: rtl/sharpen_blend.sv
module sharpen_blend
   import image_stream_pkg::*, unsharp_filter_pkg::*;
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    enable,
   input  logic signed [KERNEL_SIZE*COEFF_WIDTH-1:0] coeffs,
   input  logic [PIXEL_WIDTH-1:0]                  threshold,
   row_sum_if.sink                                 rows [KERNEL_SIZE],
   input  logic                                    bypass_dv,
   input  dtype_t                                  bypass_dtype,
   input  logic [PIXEL_WIDTH-1:0]                  bypass_pixel,
   input  logic [META_WIDTH-1:0]                   bypass_meta,
   output logic                                    dvo,
   output dtype_t                                  dtypeo,
   output logic [PIXEL_WIDTH-1:0]                  datao,
   output logic [META_WIDTH-1:0]                   meta_datao
);

   logic signed [ROW_SUM_WIDTH-1:0] h [KERNEL_SIZE];
   logic [KERNEL_SIZE-1:0]          row_valid;
   logic signed [ACC_WIDTH-1:0]     v_sum;
   logic signed [ACC_WIDTH-1:0]     rounded;
   logic [PIXEL_WIDTH-1:0]          filtered;
   logic [PIXEL_WIDTH:0]            diff;
   logic [PIXEL_WIDTH-1:0]          abs_diff;
   logic [PIXEL_WIDTH-1:0]          blended;

   for (genvar r = 0; r < KERNEL_SIZE; r++) begin : g_rows
      assign h[r]         = rows[r].sum;
      assign row_valid[r] = rows[r].valid;
   end

   // Vertical pass uses the same coefficients as the rows
   always_comb begin
      v_sum = '0;
      for (int r = 0; r < KERNEL_SIZE; r++) begin
         v_sum = v_sum + $signed(coeffs[r*COEFF_WIDTH +: COEFF_WIDTH]) * h[r];
      end
   end

   assign rounded = (v_sum + ACC_ROUND) >>> ACC_FRAC_WIDTH;

   // Clamp to the pixel range
   always_comb begin
      if (rounded[ACC_WIDTH-1]) begin
         filtered = '0;
      end else if (|rounded[ACC_WIDTH-2:PIXEL_WIDTH]) begin
         filtered = '1;
      end else begin
         filtered = rounded[PIXEL_WIDTH-1:0];
      end
   end

   assign diff     = {1'b0, filtered} - {1'b0, rows[1].center};
   assign abs_diff = diff[PIXEL_WIDTH] ? PIXEL_WIDTH'(-diff) : diff[PIXEL_WIDTH-1:0];
   // Small corrections are treated as noise and dropped
   assign blended  = (abs_diff >= threshold) ? filtered : rows[1].center;

   always_ff @(posedge clk) begin
      if (reset) begin
         dvo <= 1'b0;
      end else if (enable) begin
         dvo <= &row_valid;
      end else begin
         dvo <= bypass_dv;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         dtypeo     <= rows[1].dtype;
         datao      <= blended;
         meta_datao <= is_pixel(rows[1].dtype) ? '0 : rows[1].meta;
      end else begin
         dtypeo     <= bypass_dtype;
         datao      <= bypass_pixel;
         meta_datao <= bypass_meta;
      end
   end

endmodule

// File: rtl/unsharp_mask.sv
module unsharp_mask
   import image_stream_pkg::*, unsharp_filter_pkg::*;
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    enable,
   input  logic signed [KERNEL_SIZE*COEFF_WIDTH-1:0] coeffs,
   input  logic [PIXEL_WIDTH-1:0]                  threshold,
   input  logic                                    dvi,
   input  dtype_t                                  dtypei,
   input  logic [PIXEL_WIDTH-1:0]                  datai,
   input  logic [META_WIDTH-1:0]                   meta_datai,
   output logic                                    dvo,
   output dtype_t                                  dtypeo,
   output logic [PIXEL_WIDTH-1:0]                  datao,
   output logic [META_WIDTH-1:0]                   meta_datao
);

   // Index 0 is the top row of the window
   window_row_if taps [KERNEL_SIZE] ();
   row_sum_if    rows [KERNEL_SIZE] ();

   window_line_buffer u_line_buffer (
      .clk      (clk),
      .reset    (reset),
      .in_dv    (dvi),
      .in_dtype (dtypei),
      .in_pixel (datai),
      .in_meta  (meta_datai),
      .taps     (taps)
   );

   for (genvar r = 0; r < KERNEL_SIZE; r++) begin : g_rows
      row_filter u_row_filter (
         .clk     (clk),
         .reset   (reset),
         .coeffs  (coeffs),
         .tap     (taps[r]),
         .sum_out (rows[r])
      );
   end

   // Raw input also feeds the bypass path
   sharpen_blend u_blend (
      .clk          (clk),
      .reset        (reset),
      .enable       (enable),
      .coeffs       (coeffs),
      .threshold    (threshold),
      .rows         (rows),
      .bypass_dv    (dvi),
      .bypass_dtype (dtypei),
      .bypass_pixel (datai),
      .bypass_meta  (meta_datai),
      .dvo          (dvo),
      .dtypeo       (dtypeo),
      .datao        (datao),
      .meta_datao   (meta_datao)
   );

endmodule

// File: tests/unsharp_mask_props.sv
module unsharp_mask_props
   import image_stream_pkg::*, unsharp_filter_pkg::*;
(
   input logic      clk,
   input logic      reset,
   input logic      enable,
   input logic      dvi,
   input logic      dvo,
   input dtype_t    dtypeo,
   input lb_state_t lb_state
);

   timeunit 1ns;
   timeprecision 100ps;

   // Count of failed assertions
   int failures = 0;

   dvo_low_after_reset: assert property (@(posedge clk) reset |=> !dvo)
      else begin
         $error("dvo high in the cycle after reset");
         failures++;
      end

   dtype_legal: assert property (@(posedge clk) disable iff (reset)
      dvo |-> !$isunknown(dtypeo) && dtypeo inside
         {DT_FRAME_START, DT_FRAME_END, DT_LINE_START, DT_PIXEL, DT_LINE_END})
      else begin
         $error("dtypeo unknown or illegal while dvo is high");
         failures++;
      end

   // Bypass path is a single register stage
   bypass_delay: assert property (@(posedge clk) disable iff (reset)
      !enable |=> dvo == $past(dvi))
      else begin
         $error("dvo does not follow dvi by one cycle in bypass");
         failures++;
      end

   no_input_in_flush: assert property (@(posedge clk) disable iff (reset)
      lb_state == LB_FLUSH |-> !dvi)
      else begin
         $error("input sample arrived while the line buffer replays its last line");
         failures++;
      end

endmodule

bind unsharp_mask unsharp_mask_props u_props (
   .clk      (clk),
   .reset    (reset),
   .enable   (enable),
   .dvi      (dvi),
   .dvo      (dvo),
   .dtypeo   (dtypeo),
   .lb_state (u_line_buffer.state)
);

// File: tests/unsharp_mask_tb.sv
module unsharp_mask_tb
   import image_stream_pkg::*, unsharp_filter_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD = 40;
   localparam int MAX_W      = 8;
   localparam int MAX_H      = 6;
   localparam int LINE_GAP   = 2;
   // Idle time the source owes after each frame-end marker
   localparam int FRAME_GAP  = MAX_COLS + 8;

   logic                                    clk = 1'b0;
   logic                                    reset;
   logic                                    enable;
   logic signed [KERNEL_SIZE*COEFF_WIDTH-1:0] coeffs;
   logic [PIXEL_WIDTH-1:0]                  threshold;
   logic                                    dvi;
   dtype_t                                  dtypei;
   logic [PIXEL_WIDTH-1:0]                  datai;
   logic [META_WIDTH-1:0]                   meta_datai;
   logic                                    dvo;
   dtype_t                                  dtypeo;
   logic [PIXEL_WIDTH-1:0]                  datao;
   logic [META_WIDTH-1:0]                   meta_datao;

   logic [31:0] lfsr = 32'ha013;
   int          pix [MAX_H][MAX_W];
   int          coef [KERNEL_SIZE];
   int          thr;
   int          errors;
   int          test_errors;
   int          tests_run;
   int          tests_failed;

   // Marker data is a don't care when filtering, stored as -1
   dtype_t exp_dtype [$];
   int     exp_data [$];
   int     exp_meta [$];
   dtype_t got_dtype [$];
   int     got_data [$];
   int     got_meta [$];

   always #(CLK_PERIOD / 2) clk = ~clk;

   unsharp_mask UUT (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .coeffs     (coeffs),
      .threshold  (threshold),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .datai      (datai),
      .meta_datai (meta_datai),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .datao      (datao),
      .meta_datao (meta_datao)
   );

   // Output collector, sampled away from the driving edge
   always @(negedge clk) begin
      if (dvo === 1'b1) begin
         got_dtype.push_back(dtypeo);
         got_data.push_back(int'(datao));
         got_meta.push_back(int'(meta_datao));
      end
   end

   // Galois LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [7:0] random_byte();
      logic [7:0] b;
      for (int i = 0; i < 8; i++) begin
         b[i] = lfsr[0];
         lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      end
      return b;
   endfunction

   function automatic int frame_cycles(int w, int h);
      return 4 + h * (w + LINE_GAP) + FRAME_GAP;
   endfunction

   function automatic int clamp_index(int i, int n);
      return (i < 0) ? 0 : (i >= n) ? n - 1 : i;
   endfunction

   function automatic dtype_t line_tag(int x, int w);
      return (x == 0) ? DT_LINE_START : (x == w - 1) ? DT_LINE_END : DT_PIXEL;
   endfunction

   function automatic int pixel_meta(int x, int y);
      return 16'h8000 | (y << 8) | x;
   endfunction

   // Reference filter on the stored frame with replicated borders
   function automatic int model_pixel(int x, int y, int w, int h);
      int v;
      int hs;
      int f;
      int d;
      v = 0;
      for (int r = 0; r < KERNEL_SIZE; r++) begin
         hs = 0;
         for (int k = 0; k < KERNEL_SIZE; k++) begin
            hs += coef[k] * pix[clamp_index(y + r - 1, h)][clamp_index(x + k - 1, w)];
         end
         v += coef[r] * hs;
      end
      // Two Q1.7 passes leave 14 fraction bits
      f = (v + 8192) >>> 14;
      f = (f < 0) ? 0 : (f > 255) ? 255 : f;
      d = (f > pix[y][x]) ? f - pix[y][x] : pix[y][x] - f;
      return (d >= thr) ? f : pix[y][x];
   endfunction

   task automatic configure(input logic en, input int c0, input int c1, input int c2,
                            input int t);
      @(posedge clk);
      enable    <= en;
      coeffs    <= {8'(c2), 8'(c1), 8'(c0)};
      threshold <= 8'(t);
      coef[0] = int'($signed(8'(c0)));
      coef[1] = int'($signed(8'(c1)));
      coef[2] = int'($signed(8'(c2)));
      thr = t;
   endtask

   task automatic fill_frame(input int w, input int h);
      for (int y = 0; y < h; y++) begin
         for (int x = 0; x < w; x++) begin
            pix[y][x] = random_byte();
         end
      end
   endtask

   task automatic plant_extremes();
      // Dark pixel in a bright cross pulls the sum below zero
      for (int i = 1; i <= 3; i++) begin
         pix[2][i] = 255;
         pix[i][2] = 255;
      end
      pix[2][2] = 0;
      // Bright center and corners with dark edges overshoots 255
      for (int y = 2; y <= 4; y++) begin
         for (int x = 4; x <= 6; x++) begin
            pix[y][x] = ((x + y) % 2 == 0) ? 255 : 0;
         end
      end
   endtask

   task automatic send_sample(input dtype_t dt, input int data, input int meta);
      @(posedge clk);
      dvi        <= 1'b1;
      dtypei     <= dt;
      datai      <= 8'(data);
      meta_datai <= 16'(meta);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         dvi <= 1'b0;
      end
   endtask

   task automatic send_frame(input int w, input int h, input int fs_meta, input int fe_meta);
      send_sample(DT_FRAME_START, 0, fs_meta);
      for (int y = 0; y < h; y++) begin
         for (int x = 0; x < w; x++) begin
            send_sample(line_tag(x, w), pix[y][x], pixel_meta(x, y));
         end
         idle(LINE_GAP);
      end
      send_sample(DT_FRAME_END, 0, fe_meta);
      idle(FRAME_GAP);
   endtask

   task automatic push_expected(input dtype_t dt, input int data, input int meta);
      exp_dtype.push_back(dt);
      exp_data.push_back(data);
      exp_meta.push_back(meta);
   endtask

   task automatic expect_frame(input int w, input int h, input int fs_meta, input int fe_meta,
                               input bit filtered);
      push_expected(DT_FRAME_START, filtered ? -1 : 0, fs_meta);
      for (int y = 0; y < h; y++) begin
         for (int x = 0; x < w; x++) begin
            push_expected(line_tag(x, w), filtered ? model_pixel(x, y, w, h) : pix[y][x],
                          filtered ? 0 : pixel_meta(x, y));
         end
      end
      push_expected(DT_FRAME_END, filtered ? -1 : 0, fe_meta);
   endtask

   task automatic check_outputs(input string name);
      int n;
      int waited;
      n = exp_dtype.size();
      waited = 0;
      while (got_dtype.size() < n && waited < FRAME_GAP) begin
         @(negedge clk);
         waited++;
      end
      if (got_dtype.size() != n) begin
         $display("%s: expected %0d output samples but got %0d", name, n, got_dtype.size());
         test_errors++;
      end
      if (got_dtype.size() == 0 || got_dtype[$] != DT_FRAME_END) begin
         $display("%s: no frame-end marker after the last line", name);
         test_errors++;
      end
      for (int i = 0; i < n && i < got_dtype.size(); i++) begin
         assert (got_dtype[i] == exp_dtype[i]) else begin
            $display("CHECK FAILED dtypeo sample %0d: got %h expected %h",
                     i, got_dtype[i], exp_dtype[i]);
            test_errors++;
         end
         assert (exp_data[i] < 0 || got_data[i] == exp_data[i]) else begin
            $display("CHECK FAILED datao sample %0d: got %h expected %h",
                     i, got_data[i], exp_data[i]);
            test_errors++;
         end
         assert (got_meta[i] == exp_meta[i]) else begin
            $display("CHECK FAILED meta_datao sample %0d: got %h expected %h",
                     i, got_meta[i], exp_meta[i]);
            test_errors++;
         end
      end
      exp_dtype.delete();
      exp_data.delete();
      exp_meta.delete();
      got_dtype.delete();
      got_data.delete();
      got_meta.delete();
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", name, test_errors);
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   task automatic bypass_frame();
      configure(1'b0, 0, 128, 0, 0);
      fill_frame(6, 5);
      expect_frame(6, 5, 16'h1a01, 16'h1a02, 1'b0);
      send_frame(6, 5, 16'h1a01, 16'h1a02);
      check_outputs("bypass");
      finish_test("bypass");
   endtask

   task automatic identity_kernel();
      // 128 reads as minus one, and the vertical pass squares it back to one
      configure(1'b1, 0, 128, 0, 0);
      fill_frame(6, 5);
      expect_frame(6, 5, 16'h2b01, 16'h2b02, 1'b1);
      send_frame(6, 5, 16'h2b01, 16'h2b02);
      check_outputs("identity");
      finish_test("identity");
   endtask

   task automatic sharpen_frame();
      // Center tap at the top of the Q1.7 range
      configure(1'b1, -32, 127, -32, 0);
      fill_frame(8, 6);
      plant_extremes();
      expect_frame(8, 6, 16'h3c01, 16'h3c02, 1'b1);
      send_frame(8, 6, 16'h3c01, 16'h3c02);
      check_outputs("sharpen");
      finish_test("sharpen");
   endtask

   task automatic threshold_frame();
      // Same stored frame as the sharpening run
      configure(1'b1, -32, 127, -32, 40);
      expect_frame(8, 6, 16'h4d01, 16'h4d02, 1'b1);
      send_frame(8, 6, 16'h4d01, 16'h4d02);
      check_outputs("threshold");
      finish_test("threshold");
   endtask

   task automatic frame_structure();
      configure(1'b1, -32, 127, -32, 0);
      fill_frame(7, 4);
      expect_frame(7, 4, 16'h5e01, 16'h5e02, 1'b1);
      send_frame(7, 4, 16'h5e01, 16'h5e02);
      check_outputs("frame_structure");
      fill_frame(5, 3);
      expect_frame(5, 3, 16'h5f01, 16'h5f02, 1'b1);
      send_frame(5, 3, 16'h5f01, 16'h5f02);
      check_outputs("frame_structure");
      finish_test("frame_structure");
   endtask

   initial begin : watchdog
      int budget;
      budget = 5 + 2 * frame_cycles(6, 5) + 2 * frame_cycles(8, 6)
             + frame_cycles(7, 4) + frame_cycles(5, 3);
      #(4 * budget * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      reset        = 1'b1;
      enable       = 1'b0;
      coeffs       = '0;
      threshold    = '0;
      dvi          = 1'b0;
      dtypei       = DT_PIXEL;
      datai        = '0;
      meta_datai   = '0;
      errors       = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      bypass_frame();
      identity_kernel();
      sharpen_frame();
      threshold_frame();
      frame_structure();
      $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
               tests_run, tests_failed, errors, UUT.u_props.failures);
      if (errors == 0 && UUT.u_props.failures == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: unsharp_mask.f
rtl/image_stream_pkg.sv
rtl/unsharp_filter_pkg.sv
rtl/window_row_if.sv
rtl/row_sum_if.sv
rtl/window_line_buffer.sv
rtl/row_filter.sv
rtl/sharpen_blend.sv
rtl/unsharp_mask.sv
tests/unsharp_mask_props.sv
tests/unsharp_mask_tb.sv
